//--- dma_backend.f
common/dma_pkg.sv
common/dma_job_if.sv
logic/stream_fifo.sv
logic/backend_ctrl.sv
datapath/obi_reader.sv
datapath/axi_writer.sv
logic/dma_backend.sv
verification/dma_backend_chk.sv
verification/tb_dma_backend.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_dma_backend
FILELIST  ?= dma_backend.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(SIM_ARGS) > $(LOG) 2>&1; echo "simulator exit status $$?" >> $(LOG)
	cat $(LOG)
	! grep -q "Test failures found" $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verification/tb_dma_backend.sv
`default_nettype none

module tb_dma_backend;

    localparam int unsigned ClkPeriod = 4;
    localparam int unsigned ResetCycles = 4;
    localparam int unsigned NumRandom = 20;
    // Three directed transfers on top of the random ones
    localparam int unsigned NumTransfers = NumRandom + 3;
    localparam int unsigned MaxBytes = 64;
    // Rough worst case with every channel stalling
    localparam int unsigned CyclesPerWord = 32;
    localparam int unsigned Timeout =
        NumTransfers * (MaxBytes / 4) * CyclesPerWord * ClkPeriod + ResetCycles * ClkPeriod;
    localparam dma_pkg::data_t PatternKey = 32'h5a3c_96e1;

    logic clk;
    logic arst_n;
    logic req_valid_i;
    logic req_ready_o;
    dma_pkg::addr_t req_src_i;
    dma_pkg::addr_t req_dst_i;
    dma_pkg::len_t req_len_i;
    logic req_last_i;
    logic rsp_valid_o;
    logic rsp_ready_i;
    logic rsp_last_o;
    logic rsp_error_o;
    logic obi_req_o;
    dma_pkg::addr_t obi_addr_o;
    logic obi_gnt_i;
    logic obi_rvalid_i;
    dma_pkg::data_t obi_rdata_i;
    logic aw_valid_o;
    dma_pkg::addr_t aw_addr_o;
    dma_pkg::beats_t aw_len_o;
    logic aw_ready_i;
    logic w_valid_o;
    dma_pkg::data_t w_data_o;
    logic w_last_o;
    logic w_ready_i;
    logic b_valid_i;
    logic b_ready_o;

    // Scoreboard state
    int unsigned errors = 0;
    int unsigned checks = 0;
    int unsigned test_err_start = 0;
    int unsigned tests_run = 0;
    int unsigned tests_clean = 0;
    int unsigned issued = 0;
    int unsigned accepted = 0;
    int unsigned rsp_count = 0;
    int unsigned w_beats = 0;
    int unsigned obi_req_cycles = 0;
    int unsigned aw_cycles = 0;
    int unsigned b_owed = 0;
    int unsigned wr_beat = 0;
    int unsigned stall_pct = 0;
    bit b_taken = 1'b0;
    // Reads granted and waiting for rvalid
    dma_pkg::addr_t rd_q[$];
    bit exp_last_q[$];
    dma_pkg::addr_t exp_aw_addr_q[$];
    dma_pkg::beats_t exp_aw_len_q[$];
    // Accepted bursts still taking W beats
    dma_pkg::addr_t aw_addr_q[$];
    dma_pkg::beats_t aw_len_q[$];
    dma_pkg::data_t dst_mem[dma_pkg::addr_t];
    dma_pkg::addr_t rnd_src[NumRandom];
    dma_pkg::addr_t rnd_dst[NumRandom];
    dma_pkg::len_t rnd_len[NumRandom];

    dma_backend DUT (.*, .clk_i(clk), .arst_n_i(arst_n));

    initial begin
        clk = 1'b0;
        forever begin
            #(ClkPeriod / 2) clk = ~clk;
        end
    end

    initial begin
        #(Timeout);
        $display("ERROR: watchdog expired after %0d time units, DUT stopped responding", Timeout);
        $display("Test failures found");
        $finish;
    end

    // ------------------------------
    // Helpers
    // ------------------------------

    // Source memory content, unique per address
    function automatic dma_pkg::data_t source_word(input dma_pkg::addr_t a);
        return {16'h0000, a} ^ PatternKey;
    endfunction

    function automatic bit stall_now();
        return ($urandom % 100) < stall_pct;
    endfunction

    task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("FAIL t=%0t %s: got %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic expect_true(input bit cond, input string what);
        checks++;
        assert (cond) else begin
            $display("ERROR t=%0t: %s", $time, what);
            errors++;
        end
    endtask

    // Called on a falling edge, returns on the falling edge after acceptance
    task automatic send_request(input dma_pkg::addr_t src, input dma_pkg::addr_t dst,
                                input dma_pkg::len_t len, input bit last);
        int unsigned target;
        target = accepted + 1;
        req_valid_i = 1'b1;
        req_src_i = src;
        req_dst_i = dst;
        req_len_i = len;
        req_last_i = last;
        while (accepted < target) @(negedge clk);
        req_valid_i = 1'b0;
        issued++;
    endtask

    task automatic wait_responses(input int unsigned n);
        while (rsp_count < n) @(negedge clk);
    endtask

    task automatic check_copy(input dma_pkg::addr_t src, input dma_pkg::addr_t dst,
                              input dma_pkg::len_t len);
        dma_pkg::addr_t a;
        for (int w = 0; w < int'(len) / 4; w++) begin
            a = dst + dma_pkg::addr_t'(w * 4);
            if (!dst_mem.exists(a)) begin
                expect_true(1'b0, $sformatf("destination word %h was never written", a));
            end else begin
                expect_eq($sformatf("mem[%h]", a), dst_mem[a],
                          source_word(src + dma_pkg::addr_t'(w * 4)));
            end
        end
    endtask

    task automatic start_test();
        test_err_start = errors;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == test_err_start) tests_clean++;
        $display("test %0d %s: %s, %0d failed checks", tests_run, name,
                 (errors == test_err_start) ? "ok" : "FAILED", errors - test_err_start);
    endtask

    // ------------------------------
    // Slave models
    // ------------------------------

    // Inputs change on the falling edge only
    always @(negedge clk) begin
        obi_gnt_i = !stall_now();
        aw_ready_i = !stall_now();
        w_ready_i = !stall_now();
        rsp_ready_i = !stall_now();
        // In-order read return, at least one cycle after grant
        if (rd_q.size() != 0 && !stall_now()) begin
            obi_rvalid_i = 1'b1;
            obi_rdata_i = source_word(rd_q.pop_front());
        end else begin
            obi_rvalid_i = 1'b0;
            obi_rdata_i = '0;
        end
        // B held until taken, one per finished burst
        if (!b_valid_i || b_taken) begin
            b_valid_i = (b_owed != 0) && !stall_now();
        end
        b_taken = 1'b0;
    end

    // Handshakes seen the way the DUT sees them
    always @(posedge clk) begin
        bit zero_accept;
        zero_accept = 1'b0;
        if (arst_n) begin
            if (req_valid_i && req_ready_o) begin
                accepted++;
                if (req_len_i == '0) begin
                    zero_accept = 1'b1;
                    expect_true(rsp_valid_o, "zero-length request not answered when accepted");
                end else begin
                    exp_last_q.push_back(req_last_i);
                    exp_aw_addr_q.push_back(req_dst_i);
                    exp_aw_len_q.push_back(dma_pkg::beats_t'(int'(req_len_i) / 4 - 1));
                end
            end
            if (obi_req_o) obi_req_cycles++;
            if (aw_valid_o) aw_cycles++;
            if (obi_req_o && obi_gnt_i) rd_q.push_back(obi_addr_o);
            if (aw_valid_o && aw_ready_i) begin
                if (exp_aw_addr_q.size() == 0) begin
                    expect_true(1'b0, "AW issued with no request outstanding");
                end else begin
                    expect_eq("aw_addr_o", aw_addr_o, exp_aw_addr_q.pop_front());
                    expect_eq("aw_len_o", aw_len_o, exp_aw_len_q.pop_front());
                end
                aw_addr_q.push_back(aw_addr_o);
                aw_len_q.push_back(aw_len_o);
            end
            if (w_valid_o && w_ready_i) begin
                w_beats++;
                if (aw_addr_q.size() == 0) begin
                    expect_true(1'b0, "W beat arrived before its AW");
                end else begin
                    dst_mem[aw_addr_q[0] + dma_pkg::addr_t'(wr_beat * 4)] = w_data_o;
                    expect_eq("w_last_o", w_last_o, wr_beat == int'(aw_len_q[0]));
                    if (wr_beat == int'(aw_len_q[0])) begin
                        void'(aw_addr_q.pop_front());
                        void'(aw_len_q.pop_front());
                        wr_beat = 0;
                        b_owed++;
                    end else begin
                        wr_beat++;
                    end
                end
            end
            if (b_valid_i && b_ready_o) begin
                b_owed--;
                b_taken = 1'b1;
            end
            if (rsp_valid_o && rsp_ready_i) begin
                rsp_count++;
                if (zero_accept) begin
                    expect_eq("rsp_error_o", rsp_error_o, 1);
                    expect_eq("rsp_last_o", rsp_last_o, 1);
                end else if (exp_last_q.size() == 0) begin
                    expect_true(1'b0, "response with no request outstanding");
                end else begin
                    expect_eq("rsp_error_o", rsp_error_o, 0);
                    expect_eq("rsp_last_o", rsp_last_o, exp_last_q.pop_front());
                end
            end
        end
    end

    // ------------------------------
    // Stimulus
    // ------------------------------

    initial begin
        int unsigned wait_cycles;
        int unsigned obi_before;
        int unsigned aw_before;
        int unsigned rsp_before;
        int unsigned beats_before;
        void'($urandom(32'hc85d_86eb));
        arst_n = 1'b0;
        req_valid_i = 1'b0;
        req_src_i = '0;
        req_dst_i = '0;
        req_len_i = dma_pkg::len_t'(4);
        req_last_i = 1'b0;
        rsp_ready_i = 1'b1;
        obi_gnt_i = 1'b0;
        obi_rvalid_i = 1'b0;
        obi_rdata_i = '0;
        aw_ready_i = 1'b0;
        w_ready_i = 1'b0;
        b_valid_i = 1'b0;
        repeat (ResetCycles) @(negedge clk);
        arst_n = 1'b1;

        // Outputs quiet, ready comes up one cycle later
        start_test();
        #1;
        expect_eq("rsp_valid_o", rsp_valid_o, 0);
        expect_eq("obi_req_o", obi_req_o, 0);
        expect_eq("aw_valid_o", aw_valid_o, 0);
        expect_eq("w_valid_o", w_valid_o, 0);
        expect_eq("req_ready_o", req_ready_o, 0);
        wait_cycles = 0;
        while (!req_ready_o && wait_cycles < 4) begin
            @(posedge clk);
            #1;
            wait_cycles++;
        end
        expect_true(req_ready_o, "req_ready_o did not rise after reset");
        @(negedge clk);
        finish_test("reset");

        // Single word
        start_test();
        beats_before = w_beats;
        send_request(16'h0100, 16'h8000, dma_pkg::len_t'(4), 1'b1);
        wait_responses(issued);
        expect_eq("W beats", w_beats - beats_before, 1);
        check_copy(16'h0100, 16'h8000, dma_pkg::len_t'(4));
        finish_test("single word");

        // Longest burst
        start_test();
        beats_before = w_beats;
        send_request(16'h0200, 16'h8100, dma_pkg::len_t'(MaxBytes), 1'b0);
        wait_responses(issued);
        expect_eq("W beats", w_beats - beats_before, 16);
        check_copy(16'h0200, 16'h8100, dma_pkg::len_t'(MaxBytes));
        finish_test("full burst");

        // Rejected request, last forced high in the response
        start_test();
        obi_before = obi_req_cycles;
        aw_before = aw_cycles;
        rsp_before = rsp_count;
        send_request(16'h0300, 16'h8200, '0, 1'b0);
        repeat (8) @(negedge clk);
        expect_eq("responses", rsp_count - rsp_before, 1);
        expect_eq("obi_req_o cycles", obi_req_cycles - obi_before, 0);
        expect_eq("aw_valid_o cycles", aw_cycles - aw_before, 0);
        finish_test("zero length");

        // Back-to-back copies under random stalls
        start_test();
        stall_pct = 40;
        for (int i = 0; i < NumRandom; i++) begin
            rnd_src[i] = dma_pkg::addr_t'(($urandom % 4096) * 4);
            rnd_dst[i] = dma_pkg::addr_t'(16'h9000 + i * MaxBytes);
            rnd_len[i] = dma_pkg::len_t'((1 + $urandom % 16) * 4);
            send_request(rnd_src[i], rnd_dst[i], rnd_len[i], 1'($urandom % 2));
            repeat ($urandom % 3) @(negedge clk);
        end
        wait_responses(issued);
        for (int i = 0; i < NumRandom; i++) begin
            check_copy(rnd_src[i], rnd_dst[i], rnd_len[i]);
        end
        expect_eq("responses", rsp_count, issued);
        expect_eq("queued last flags", exp_last_q.size(), 0);
        finish_test("random copies");

        $display("summary: %0d tests, %0d clean, %0d checks, %0d failed, %0d assertion failures",
                 tests_run, tests_clean, checks, errors, DUT.i_chk.assert_failures);
        if (errors == 0 && DUT.i_chk.assert_failures == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/dma_backend_chk.sv
`default_nettype none

module dma_backend_chk (
    input wire logic clk_i,
    input wire logic arst_n_i,
    input wire logic obi_req_o,
    input wire dma_pkg::addr_t obi_addr_o,
    input wire logic obi_gnt_i,
    input wire logic aw_valid_o,
    input wire dma_pkg::addr_t aw_addr_o,
    input wire dma_pkg::beats_t aw_len_o,
    input wire logic aw_ready_i,
    input wire logic w_valid_o,
    input wire dma_pkg::data_t w_data_o,
    input wire logic w_last_o,
    input wire logic w_ready_i,
    input wire logic rsp_valid_o
);

    // Failed assertions, read back by the testbench
    int unsigned assert_failures = 0;

    // OBI request and address held until grant
    obi_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        obi_req_o && !obi_gnt_i |=> obi_req_o && $stable(obi_addr_o))
        else begin
            $error("OBI request dropped or its address changed before grant");
            assert_failures++;
        end

    // AW payload frozen while stalled
    aw_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        aw_valid_o && !aw_ready_i |=> aw_valid_o && $stable(aw_addr_o) && $stable(aw_len_o))
        else begin
            $error("AW valid dropped or its payload changed before ready");
            assert_failures++;
        end

    // W payload frozen while stalled
    w_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        w_valid_o && !w_ready_i |=> w_valid_o && $stable(w_data_o) && $stable(w_last_o))
        else begin
            $error("W valid dropped or its payload changed before ready");
            assert_failures++;
        end

    // No response out of reset
    rsp_quiet: assert property (@(posedge clk_i) !arst_n_i |-> !rsp_valid_o)
        else begin
            $error("Response valid seen while reset is active");
            assert_failures++;
        end

endmodule

bind dma_backend dma_backend_chk i_chk (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .obi_req_o  (obi_req_o),
    .obi_addr_o (obi_addr_o),
    .obi_gnt_i  (obi_gnt_i),
    .aw_valid_o (aw_valid_o),
    .aw_addr_o  (aw_addr_o),
    .aw_len_o   (aw_len_o),
    .aw_ready_i (aw_ready_i),
    .w_valid_o  (w_valid_o),
    .w_data_o   (w_data_o),
    .w_last_o   (w_last_o),
    .w_ready_i  (w_ready_i),
    .rsp_valid_o(rsp_valid_o)
);

`default_nettype wire

//--- logic/dma_backend.sv
`default_nettype none

module dma_backend (
    input  wire logic clk_i,
    input  wire logic arst_n_i,
    // Request
    input  wire logic req_valid_i,
    output logic req_ready_o,
    input  wire dma_pkg::addr_t req_src_i,
    input  wire dma_pkg::addr_t req_dst_i,
    input  wire dma_pkg::len_t req_len_i,
    input  wire logic req_last_i,
    // Response
    output logic rsp_valid_o,
    input  wire logic rsp_ready_i,
    output logic rsp_last_o,
    output logic rsp_error_o,
    // OBI read port
    output logic obi_req_o,
    output dma_pkg::addr_t obi_addr_o,
    input  wire logic obi_gnt_i,
    input  wire logic obi_rvalid_i,
    input  wire dma_pkg::data_t obi_rdata_i,
    // AXI write port
    output logic aw_valid_o,
    output dma_pkg::addr_t aw_addr_o,
    output dma_pkg::beats_t aw_len_o,
    input  wire logic aw_ready_i,
    output logic w_valid_o,
    output dma_pkg::data_t w_data_o,
    output logic w_last_o,
    input  wire logic w_ready_i,
    input  wire logic b_valid_i,
    output logic b_ready_o
);

    dma_job_if rd_job ();
    dma_job_if wr_job ();

    // Data buffer between the engines
    logic buf_in_valid;
    dma_pkg::data_t buf_in_data;
    logic buf_out_valid;
    logic buf_out_ready;
    dma_pkg::data_t buf_out_data;
    dma_pkg::fill_t buf_fill;
    // Burst completion
    logic done_valid;
    logic done_ready;

    backend_ctrl i_ctrl (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .req_src_i   (req_src_i),
        .req_dst_i   (req_dst_i),
        .req_len_i   (req_len_i),
        .req_last_i  (req_last_i),
        .rsp_valid_o (rsp_valid_o),
        .rsp_ready_i (rsp_ready_i),
        .rsp_last_o  (rsp_last_o),
        .rsp_error_o (rsp_error_o),
        .rd_job      (rd_job),
        .wr_job      (wr_job),
        .done_valid_i(done_valid),
        .done_ready_o(done_ready)
    );

    obi_reader i_reader (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .job         (rd_job),
        .obi_req_o   (obi_req_o),
        .obi_addr_o  (obi_addr_o),
        .obi_gnt_i   (obi_gnt_i),
        .obi_rvalid_i(obi_rvalid_i),
        .obi_rdata_i (obi_rdata_i),
        .buf_valid_o (buf_in_valid),
        .buf_data_o  (buf_in_data),
        .buf_fill_i  (buf_fill)
    );

    // Reader credit keeps this from overflowing
    stream_fifo #(
        .Depth(dma_pkg::BufferDepth),
        .T    (dma_pkg::data_t)
    ) i_buffer (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .in_valid_i (buf_in_valid),
        .in_ready_o (),
        .in_data_i  (buf_in_data),
        .out_valid_o(buf_out_valid),
        .out_ready_i(buf_out_ready),
        .out_data_o (buf_out_data),
        .fill_o     (buf_fill)
    );

    axi_writer i_writer (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .job         (wr_job),
        .aw_valid_o  (aw_valid_o),
        .aw_addr_o   (aw_addr_o),
        .aw_len_o    (aw_len_o),
        .aw_ready_i  (aw_ready_i),
        .w_valid_o   (w_valid_o),
        .w_data_o    (w_data_o),
        .w_last_o    (w_last_o),
        .w_ready_i   (w_ready_i),
        .buf_valid_i (buf_out_valid),
        .buf_ready_o (buf_out_ready),
        .buf_data_i  (buf_out_data),
        .b_valid_i   (b_valid_i),
        .b_ready_o   (b_ready_o),
        .done_valid_o(done_valid),
        .done_ready_i(done_ready)
    );

endmodule

`default_nettype wire

//--- datapath/axi_writer.sv
`default_nettype none

module axi_writer (
    input  wire logic clk_i,
    input  wire logic arst_n_i,
    dma_job_if.engine job,
    // AW channel
    output logic aw_valid_o,
    output dma_pkg::addr_t aw_addr_o,
    output dma_pkg::beats_t aw_len_o,
    input  wire logic aw_ready_i,
    // W channel
    output logic w_valid_o,
    output dma_pkg::data_t w_data_o,
    output logic w_last_o,
    input  wire logic w_ready_i,
    // Pop side of the data buffer
    input  wire logic buf_valid_i,
    output logic buf_ready_o,
    input  wire dma_pkg::data_t buf_data_i,
    // B channel and completion to control
    input  wire logic b_valid_i,
    output logic b_ready_o,
    output logic done_valid_o,
    input  wire logic done_ready_i
);

    dma_pkg::wr_state_e state_q;
    dma_pkg::wr_state_e state_d;
    logic q_valid;
    logic q_ready;
    dma_pkg::job_t q_data;
    dma_pkg::beats_t beat_q;
    logic w_fire;

    stream_fifo #(
        .Depth(dma_pkg::JobDepth),
        .T    (dma_pkg::job_t)
    ) i_job_queue (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .in_valid_i (job.valid),
        .in_ready_o (job.ready),
        .in_data_i  ({job.addr, job.beats}),
        .out_valid_o(q_valid),
        .out_ready_i(q_ready),
        .out_data_o (q_data),
        .fill_o     ()
    );

    // Job stays at the queue head until its last beat, so AW payload is stable
    assign aw_addr_o = q_data[dma_pkg::AddrWidth+dma_pkg::BeatWidth-1:dma_pkg::BeatWidth];
    assign aw_len_o = q_data[dma_pkg::BeatWidth-1:0];
    assign aw_valid_o = state_q == dma_pkg::WR_ADDR;

    // W beats as buffer words arrive
    assign w_valid_o = (state_q == dma_pkg::WR_DATA) && buf_valid_i;
    assign w_data_o = buf_data_i;
    assign w_last_o = beat_q == aw_len_o;
    assign buf_ready_o = (state_q == dma_pkg::WR_DATA) && w_ready_i;
    assign w_fire = w_valid_o && w_ready_i;
    assign q_ready = w_fire && w_last_o;

    always_comb begin
        state_d = state_q;
        case (state_q)
            dma_pkg::WR_IDLE: if (q_valid) state_d = dma_pkg::WR_ADDR;
            dma_pkg::WR_ADDR: if (aw_ready_i) state_d = dma_pkg::WR_DATA;
            dma_pkg::WR_DATA: if (q_ready) state_d = dma_pkg::WR_IDLE;
            default: state_d = dma_pkg::WR_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= dma_pkg::WR_IDLE;
            beat_q <= '0;
        end else begin
            state_q <= state_d;
            if (w_fire) begin
                beat_q <= w_last_o ? '0 : beat_q + dma_pkg::beats_t'(1);
            end
        end
    end

    // Bursts complete in order, B maps one to one on completions
    assign done_valid_o = b_valid_i;
    assign b_ready_o = done_ready_i;

endmodule

`default_nettype wire

//--- datapath/obi_reader.sv
`default_nettype none

module obi_reader (
    input  wire logic clk_i,
    input  wire logic arst_n_i,
    dma_job_if.engine job,
    // OBI read port
    output logic obi_req_o,
    output dma_pkg::addr_t obi_addr_o,
    input  wire logic obi_gnt_i,
    input  wire logic obi_rvalid_i,
    input  wire dma_pkg::data_t obi_rdata_i,
    // Push side of the data buffer
    output logic buf_valid_o,
    output dma_pkg::data_t buf_data_o,
    input  wire dma_pkg::fill_t buf_fill_i
);

    logic q_valid;
    logic q_ready;
    dma_pkg::job_t q_data;
    dma_pkg::addr_t q_addr;
    dma_pkg::beats_t q_beats;
    // Next beat of the current job
    dma_pkg::beats_t beat_q;
    // Reads granted but not yet returned
    dma_pkg::fill_t out_q;
    logic [dma_pkg::FillWidth:0] credit_used;
    logic issue;

    stream_fifo #(
        .Depth(dma_pkg::JobDepth),
        .T    (dma_pkg::job_t)
    ) i_job_queue (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .in_valid_i (job.valid),
        .in_ready_o (job.ready),
        .in_data_i  ({job.addr, job.beats}),
        .out_valid_o(q_valid),
        .out_ready_i(q_ready),
        .out_data_o (q_data),
        .fill_o     ()
    );

    assign q_addr = q_data[dma_pkg::AddrWidth+dma_pkg::BeatWidth-1:dma_pkg::BeatWidth];
    assign q_beats = q_data[dma_pkg::BeatWidth-1:0];

    // Every buffer slot is either filled or owed by a read in flight
    // Sum cannot rise while a request waits, so req holds until gnt
    assign credit_used = {1'b0, out_q} + {1'b0, buf_fill_i};
    assign obi_req_o = q_valid && (32'(credit_used) < dma_pkg::BufferDepth);
    assign obi_addr_o = q_addr + dma_pkg::addr_t'({beat_q, 2'b00});

    assign issue = obi_req_o && obi_gnt_i;
    // Job leaves the queue with its last grant
    assign q_ready = issue && (beat_q == q_beats);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            beat_q <= '0;
            out_q <= '0;
        end else begin
            if (issue) begin
                beat_q <= q_ready ? '0 : beat_q + dma_pkg::beats_t'(1);
            end
            if (issue && !obi_rvalid_i) begin
                out_q <= out_q + dma_pkg::fill_t'(1);
            end else if (obi_rvalid_i && !issue) begin
                out_q <= out_q - dma_pkg::fill_t'(1);
            end
        end
    end

    // Room is reserved by the credit, so no ready is checked
    assign buf_valid_o = obi_rvalid_i;
    assign buf_data_o = obi_rdata_i;

endmodule

`default_nettype wire

//--- logic/backend_ctrl.sv
`default_nettype none

module backend_ctrl (
    input  wire logic clk_i,
    input  wire logic arst_n_i,
    // Request channel
    input  wire logic req_valid_i,
    output logic req_ready_o,
    input  wire dma_pkg::addr_t req_src_i,
    input  wire dma_pkg::addr_t req_dst_i,
    input  wire dma_pkg::len_t req_len_i,
    input  wire logic req_last_i,
    // Response channel
    output logic rsp_valid_o,
    input  wire logic rsp_ready_i,
    output logic rsp_last_o,
    output logic rsp_error_o,
    // Jobs to the engines
    dma_job_if.ctrl rd_job,
    dma_job_if.ctrl wr_job,
    // Burst completion from the write engine
    input  wire logic done_valid_i,
    output logic done_ready_o
);

    // High from the second cycle after reset on
    logic armed_q;
    logic len_zero;
    logic req_go;
    logic zero_accept;
    dma_pkg::beats_t beats;
    // Last-flag queue
    logic flag_push;
    logic flag_ready;
    logic flag_valid;
    logic flag_last;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            armed_q <= 1'b0;
        end else begin
            armed_q <= 1'b1;
        end
    end

    // ------------------------------
    // Request fork
    // ------------------------------

    assign len_zero = req_len_i == '0;
    assign req_go = armed_q && req_valid_i && !len_zero;

    // Whole words only, one burst per transfer
    assign beats = dma_pkg::beats_t'((req_len_i >> 2) - dma_pkg::len_t'(1));

    // Each branch waits for the other two, so all three push together
    assign rd_job.valid = req_go && wr_job.ready && flag_ready;
    assign wr_job.valid = req_go && rd_job.ready && flag_ready;
    assign flag_push = req_go && rd_job.ready && wr_job.ready;

    assign rd_job.addr = req_src_i;
    assign rd_job.beats = beats;
    assign wr_job.addr = req_dst_i;
    assign wr_job.beats = beats;

    // Zero length goes straight to the response channel
    assign req_ready_o = armed_q &&
        (len_zero ? rsp_ready_i : (rd_job.ready && wr_job.ready && flag_ready));

    // Queued last flags, one per burst in flight
    stream_fifo #(
        .Depth(dma_pkg::JobDepth),
        .T    (logic)
    ) i_last_queue (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .in_valid_i (flag_push),
        .in_ready_o (flag_ready),
        .in_data_i  (req_last_i),
        .out_valid_o(flag_valid),
        .out_ready_i(done_valid_i && done_ready_o),
        .out_data_o (flag_last),
        .fill_o     ()
    );

    // ------------------------------
    // Response
    // ------------------------------

    // Rejection answered in the acceptance cycle
    assign zero_accept = req_valid_i && len_zero && req_ready_o;

    assign rsp_valid_o = zero_accept || (done_valid_i && flag_valid);
    assign rsp_error_o = zero_accept;
    assign rsp_last_o = zero_accept || flag_last;

    // Pending B waits while a rejection takes the channel
    assign done_ready_o = rsp_ready_i && flag_valid && !zero_accept;

endmodule

`default_nettype wire

//--- logic/stream_fifo.sv
`default_nettype none

module stream_fifo #(
    parameter int unsigned Depth = 2,
    parameter type T = logic
) (
    input  wire logic clk_i,
    input  wire logic arst_n_i,
    input  wire logic in_valid_i,
    output logic in_ready_o,
    input  wire T in_data_i,
    output logic out_valid_o,
    input  wire logic out_ready_i,
    output T out_data_o,
    output logic [$clog2(Depth+1)-1:0] fill_o
);

    typedef logic [$clog2(Depth)-1:0] ptr_t;
    typedef logic [$clog2(Depth+1)-1:0] cnt_t;

    // Storage, no reset needed on payload
    T mem_q [Depth];
    ptr_t wr_ptr_q;
    ptr_t rd_ptr_q;
    cnt_t fill_q;
    logic push;
    logic pop;

    // Not fall-through, data shows one cycle after the push
    assign in_ready_o = fill_q < Depth;
    assign out_valid_o = fill_q != '0;
    assign out_data_o = mem_q[rd_ptr_q];
    assign fill_o = fill_q;

    assign push = in_valid_i && in_ready_o;
    assign pop = out_valid_o && out_ready_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            fill_q <= '0;
        end else begin
            // Pointers wrap at Depth, works for any depth
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == ptr_t'(Depth - 1)) ? '0 : wr_ptr_q + ptr_t'(1);
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == ptr_t'(Depth - 1)) ? '0 : rd_ptr_q + ptr_t'(1);
            end
            // Push and pop together leave the level alone
            if (push && !pop) begin
                fill_q <= fill_q + cnt_t'(1);
            end else if (pop && !push) begin
                fill_q <= fill_q - cnt_t'(1);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= in_data_i;
        end
    end

endmodule

`default_nettype wire

//--- common/dma_job_if.sv
`default_nettype none

// One read or write job from the control block to a datapath engine
interface dma_job_if;

    logic valid;
    logic ready;
    // Word aligned start address
    dma_pkg::addr_t addr;
    // Number of words minus one
    dma_pkg::beats_t beats;

    // Control side presents the job
    modport ctrl (
        output valid,
        output addr,
        output beats,
        input  ready
    );

    // Engine side takes it
    modport engine (
        input  valid,
        input  addr,
        input  beats,
        output ready
    );

endinterface

`default_nettype wire

//--- common/dma_pkg.sv
`default_nettype none

package dma_pkg;

    // ------------------------------
    // Widths and depths
    // ------------------------------

    // Bus word width in bits
    localparam int unsigned DataWidth = 32;
    // Byte address width
    localparam int unsigned AddrWidth = 16;
    // Transfer length in bytes, up to 64
    localparam int unsigned LenWidth = 7;
    // Burst length field, at most 16 beats
    localparam int unsigned BeatWidth = 4;

    // Entries per job queue and in the last-flag queue
    localparam int unsigned JobDepth = 2;
    // Data buffer entries in words
    localparam int unsigned BufferDepth = 4;
    // Width of the data buffer fill level
    localparam int unsigned FillWidth = $clog2(BufferDepth + 1);

    // ------------------------------
    // Types
    // ------------------------------

    typedef logic [DataWidth-1:0] data_t;
    typedef logic [AddrWidth-1:0] addr_t;
    typedef logic [LenWidth-1:0] len_t;
    // Beat count minus one, as on AW
    typedef logic [BeatWidth-1:0] beats_t;
    typedef logic [FillWidth-1:0] fill_t;
    // Job queue entry, address above beat count
    typedef logic [AddrWidth+BeatWidth-1:0] job_t;

    // Write engine FSM
    typedef enum logic [1:0] {
        WR_IDLE = 2'd0,
        WR_ADDR = 2'd1,
        WR_DATA = 2'd2
    } wr_state_e;

endpackage

`default_nettype wire
